/* verilog/ppu_pkg.sv */
// ppu shared definitions
// register-select codes, bit positions and bus widths for the CPU side

package ppu_pkg;

    // register select on i_rs
    typedef enum logic [2:0]
    {
        RS_PPUCTRL   = 3'd0,
        RS_PPUSTATUS = 3'd2,
        RS_PPUADDR   = 3'd6,
        RS_PPUDATA   = 3'd7
    } ppu_reg_e;

    localparam logic RW_READ = 1'b1;            // i_rw level for a read

    typedef logic [7:0]  cpu_data_t;
    typedef logic [13:0] vram_addr_t;
    typedef logic [15:0] ppu_addr_t;
    typedef logic [5:0]  colour_index_t;

    // palette space starts here and runs to the top of the address range
    localparam ppu_addr_t PALETTE_BASE = 16'h3F00;

    // PPUCTRL bits
    localparam int CTRL_INC32_BIT = 2;          // step 32 per PPUDATA access
    localparam int CTRL_NMI_BIT = 7;            // raise NMI at vblank

    // PPUSTATUS bits
    localparam int STATUS_VBLANK_BIT = 7;

endpackage

/* verilog/ppu_timing.sv */
// ppu frame timing
// dot and line counters with visible region and vblank boundary strobes
`timescale 1ns/100ps

module ppu_timing
#(
    parameter int P_LINE_DOTS = 341,
    parameter int P_FRAME_LINES = 262,
    parameter int P_VISIBLE_DOTS = 256,
    parameter int P_VISIBLE_LINES = 240
)
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    output logic [8:0] o_x,
    output logic [8:0] o_y,
    output logic       o_visible,
    output logic       o_vblank_start,
    output logic       o_vblank_end
);

    logic [8:0] r_x;
    logic [8:0] r_y;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_x <= '0;
            r_y <= '0;
        end
        else if (r_x == 9'(P_LINE_DOTS - 1))
        begin
            r_x <= '0;      // end of line
            if (r_y == 9'(P_FRAME_LINES - 1))
            begin
                r_y <= '0;
            end
            else
            begin
                r_y <= r_y + 9'd1;
            end
        end
        else
        begin
            r_x <= r_x + 9'd1;
        end
    end

    assign o_x = r_x;
    assign o_y = r_y;
    assign o_visible = (r_x < 9'(P_VISIBLE_DOTS)) && (r_y < 9'(P_VISIBLE_LINES));

    // vblank opens two lines after the last visible line
    assign o_vblank_start = (r_x == '0) && (r_y == 9'(P_VISIBLE_LINES + 2));
    assign o_vblank_end = (r_x == '0) && (r_y == 9'(P_FRAME_LINES - 1));   // pre-render line

    a_dot_in_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        r_x < 9'(P_LINE_DOTS));

endmodule

/* verilog/ppu_registers.sv */
// ppu CPU register file
// PPUCTRL, PPUADDR with its w latch, vblank flag, NMI and the read mux
`timescale 1ns/100ps

module ppu_registers
(
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_cs_n,
    input  ppu_pkg::ppu_reg_e         i_rs,
    input  logic                      i_rw,
    input  ppu_pkg::cpu_data_t        i_data,
    input  logic                      i_vblank_start,
    input  logic                      i_vblank_end,
    input  ppu_pkg::cpu_data_t        i_buffer,
    input  ppu_pkg::colour_index_t    i_palette_rdata,
    output ppu_pkg::cpu_data_t        o_data,
    output logic                      o_int_n,
    output logic                      o_data_access,
    output logic                      o_data_write,
    output ppu_pkg::ppu_addr_t        o_data_addr,
    output ppu_pkg::cpu_data_t        o_data_wdata
);
    import ppu_pkg::*;

    cpu_data_t r_ppuctrl;
    ppu_addr_t r_ppuaddr;
    logic      r_w;                 // 0 = next PPUADDR write is the high byte
    logic      r_vblank;

    logic      w_write;
    logic      w_status_read;
    cpu_data_t w_status;
    cpu_data_t r_rdata;

    assign w_write = !i_cs_n && (i_rw != RW_READ);
    assign w_status_read = !i_cs_n && (i_rw == RW_READ) && (i_rs == RS_PPUSTATUS);

    // PPUDATA access goes to both the VRAM port and the palette
    assign o_data_access = !i_cs_n && (i_rs == RS_PPUDATA);
    assign o_data_write = w_write;
    assign o_data_addr = r_ppuaddr;
    assign o_data_wdata = i_data;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_ppuctrl <= '0;
        end
        else if (w_write && (i_rs == RS_PPUCTRL))
        begin
            r_ppuctrl <= i_data;
        end
    end

    // address counter and the shared write toggle
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_ppuaddr <= '0;
            r_w <= 1'b0;
        end
        else if (w_status_read)
        begin
            r_w <= 1'b0;
        end
        else if (w_write && (i_rs == RS_PPUADDR))
        begin
            if (!r_w)
            begin
                r_ppuaddr[15:8] <= i_data;
            end
            else
            begin
                r_ppuaddr[7:0] <= i_data;
            end
            r_w <= !r_w;
        end
        else if (o_data_access)
        begin
            r_ppuaddr <= r_ppuaddr + (r_ppuctrl[CTRL_INC32_BIT] ? 16'd32 : 16'd1);
        end
    end

    // a status read in the same cycle beats the vblank start
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_vblank <= 1'b0;
        end
        else if (w_status_read || i_vblank_end)
        begin
            r_vblank <= 1'b0;
        end
        else if (i_vblank_start)
        begin
            r_vblank <= 1'b1;
        end
    end

    assign o_int_n = !(r_vblank && r_ppuctrl[CTRL_NMI_BIT]);

    always_comb
    begin
        w_status = '0;
        w_status[STATUS_VBLANK_BIT] = r_vblank;
    end

    always_comb
    begin
        r_rdata = '0;
        if (!i_cs_n && (i_rw == RW_READ))
        begin
            case (i_rs)
                RS_PPUSTATUS:
                begin
                    r_rdata = w_status;
                end
                RS_PPUDATA:
                begin
                    if (r_ppuaddr >= PALETTE_BASE)
                    begin
                        r_rdata = {2'b00, i_palette_rdata};   // palette is immediate
                    end
                    else
                    begin
                        r_rdata = i_buffer;                   // buffered VRAM byte
                    end
                end
                default:
                begin
                    r_rdata = '0;
                end
            endcase
        end
    end

    assign o_data = r_rdata;

    a_nmi_needs_enable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !o_int_n |-> r_ppuctrl[CTRL_NMI_BIT]);

endmodule

/* verilog/ppu_vram_port.sv */
// ppu VRAM port
// two-cycle read/write sequencer with the PPUDATA read buffer
`timescale 1ns/100ps

module ppu_vram_port
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_data_access,
    input  logic                  i_data_write,
    input  ppu_pkg::ppu_addr_t    i_data_addr,
    input  ppu_pkg::cpu_data_t    i_data_wdata,
    input  ppu_pkg::cpu_data_t    i_vram_data,
    output ppu_pkg::cpu_data_t    o_buffer,
    output logic                  o_vram_rd_n,
    output logic                  o_vram_we_n,
    output ppu_pkg::vram_addr_t   o_vram_address,
    output ppu_pkg::cpu_data_t    o_vram_data
);
    import ppu_pkg::*;

    logic       w_vram_access;
    logic       r_rd_n;
    logic       r_we_n;
    cpu_data_t  r_buffer;
    vram_addr_t r_address;

    // palette addresses never reach the VRAM bus
    assign w_vram_access = i_data_access && (i_data_addr < PALETTE_BASE);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_rd_n <= 1'b1;
            r_we_n <= 1'b1;
            r_buffer <= '0;
        end
        else
        begin
            r_rd_n <= 1'b1;                 // strobes last one cycle
            r_we_n <= 1'b1;
            if (!r_rd_n)
            begin
                r_buffer <= i_vram_data;    // capture at end of read strobe
            end
            if (w_vram_access)
            begin
                if (i_data_write)
                begin
                    r_we_n <= 1'b0;
                    r_buffer <= i_data_wdata;
                end
                else
                begin
                    r_rd_n <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_vram_access)
        begin
            r_address <= i_data_addr[13:0];
        end
    end

    assign o_buffer = r_buffer;
    assign o_vram_rd_n = r_rd_n;
    assign o_vram_we_n = r_we_n;
    assign o_vram_address = r_address;
    assign o_vram_data = !r_we_n ? r_buffer : '0;

    a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(!r_rd_n && !r_we_n));

    // the CPU has to leave a gap after each PPUDATA access
    a_no_overlap: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (!r_rd_n || !r_we_n) |-> !i_data_access);

endmodule

/* verilog/ppu_palette.sv */
// ppu palette memory
// 32 entries of 6 bits, CPU access and backdrop colour from entry 0
`timescale 1ns/100ps

module ppu_palette
(
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_data_access,
    input  logic                      i_data_write,
    input  ppu_pkg::ppu_addr_t        i_data_addr,
    input  ppu_pkg::cpu_data_t        i_data_wdata,
    input  logic                      i_visible,
    output ppu_pkg::colour_index_t    o_rdata,
    output ppu_pkg::colour_index_t    o_colour_index
);
    import ppu_pkg::*;

    colour_index_t r_palette [0:31];
    logic          w_palette_write;

    // no writes land while the chip is held in reset
    assign w_palette_write = i_reset_n && i_data_access && i_data_write
                             && (i_data_addr >= PALETTE_BASE);

    always_ff @(posedge i_clk)
    begin
        if (w_palette_write)
        begin
            r_palette[i_data_addr[4:0]] <= i_data_wdata[5:0];   // top two bits dropped
        end
    end

    assign o_rdata = r_palette[i_data_addr[4:0]];
    assign o_colour_index = i_visible ? r_palette[0] : '0;   // backdrop only

endmodule

/* verilog/ppu.sv */
// ppu top level, CPU side of the picture processing unit
// joins the frame timing, register file, VRAM port and palette
`timescale 1ns/100ps

module ppu
#(
    parameter int P_LINE_DOTS = 341,
    parameter int P_FRAME_LINES = 262,
    parameter int P_VISIBLE_DOTS = 256,
    parameter int P_VISIBLE_LINES = 240
)
(
    input  logic                      i_clk,
    input  logic                      i_reset_n,
    input  logic                      i_cs_n,
    input  ppu_pkg::ppu_reg_e         i_rs,
    input  logic                      i_rw,
    input  ppu_pkg::cpu_data_t        i_data,
    output ppu_pkg::cpu_data_t        o_data,
    output logic                      o_int_n,
    output logic                      o_vram_rd_n,
    output logic                      o_vram_we_n,
    output ppu_pkg::vram_addr_t       o_vram_address,
    output ppu_pkg::cpu_data_t        o_vram_data,
    input  ppu_pkg::cpu_data_t        i_vram_data,
    output logic [8:0]                o_video_x,
    output logic [8:0]                o_video_y,
    output logic                      o_video_visible,
    output ppu_pkg::colour_index_t    o_colour_index
);
    import ppu_pkg::*;

    logic          w_vblank_start;
    logic          w_vblank_end;
    logic          w_data_access;              // PPUDATA access this cycle
    logic          w_data_write;
    ppu_addr_t     w_data_addr;
    cpu_data_t     w_data_wdata;
    cpu_data_t     w_buffer;                   // last byte seen on the VRAM bus
    colour_index_t w_palette_rdata;

    ppu_timing
    #(
        .P_LINE_DOTS     (P_LINE_DOTS),
        .P_FRAME_LINES   (P_FRAME_LINES),
        .P_VISIBLE_DOTS  (P_VISIBLE_DOTS),
        .P_VISIBLE_LINES (P_VISIBLE_LINES)
    )
    ppu_timing_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .o_x            (o_video_x),
        .o_y            (o_video_y),
        .o_visible      (o_video_visible),
        .o_vblank_start (w_vblank_start),
        .o_vblank_end   (w_vblank_end)
    );

    ppu_registers ppu_registers_inst
    (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cs_n          (i_cs_n),
        .i_rs            (i_rs),
        .i_rw            (i_rw),
        .i_data          (i_data),
        .i_vblank_start  (w_vblank_start),
        .i_vblank_end    (w_vblank_end),
        .i_buffer        (w_buffer),
        .i_palette_rdata (w_palette_rdata),
        .o_data          (o_data),
        .o_int_n         (o_int_n),
        .o_data_access   (w_data_access),
        .o_data_write    (w_data_write),
        .o_data_addr     (w_data_addr),
        .o_data_wdata    (w_data_wdata)
    );

    ppu_vram_port ppu_vram_port_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_data_access  (w_data_access),
        .i_data_write   (w_data_write),
        .i_data_addr    (w_data_addr),
        .i_data_wdata   (w_data_wdata),
        .i_vram_data    (i_vram_data),
        .o_buffer       (w_buffer),
        .o_vram_rd_n    (o_vram_rd_n),
        .o_vram_we_n    (o_vram_we_n),
        .o_vram_address (o_vram_address),
        .o_vram_data    (o_vram_data)
    );

    ppu_palette ppu_palette_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_data_access  (w_data_access),
        .i_data_write   (w_data_write),
        .i_data_addr    (w_data_addr),
        .i_data_wdata   (w_data_wdata),
        .i_visible      (o_video_visible),
        .o_rdata        (w_palette_rdata),
        .o_colour_index (o_colour_index)
    );

endmodule

/* bench/ppu_vram_model.sv */
// behavioral 16 KiB VRAM for the ppu testbench
// written on the write strobe, read data driven while the read strobe is low
`timescale 1ns/100ps

module ppu_vram_model
(
    input  logic        i_clk,
    input  logic        i_rd_n,
    input  logic        i_we_n,
    input  logic [13:0] i_address,
    input  logic [7:0]  i_data,
    output logic [7:0]  o_data
);

    logic [7:0] r_mem [0:16383];

    // fill pattern mixes low and high address bits
    initial
    begin
        for (int a = 0; a < 16384; a++)
        begin
            r_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
        end
    end

    always @(posedge i_clk)
    begin
        if (!i_we_n)
        begin
            r_mem[i_address] <= i_data;
        end
    end

    assign o_data = !i_rd_n ? r_mem[i_address] : 8'h00;   // bus idles at zero

endmodule

/* bench/ppu_tb.sv */
// ppu testbench
// random register traffic against a reference of the register, timing and VRAM rules
`timescale 1ns/100ps

module ppu_tb;
    import ppu_pkg::*;

    localparam int LINE_DOTS = 40;
    localparam int FRAME_LINES = 30;
    localparam int VIS_DOTS = 32;
    localparam int VIS_LINES = 20;
    localparam int N_RUNS = 6;               // address loads per increment mode
    localparam int N_WRITES = 3;
    localparam int N_READS = 6;
    localparam int ACCESS_COUNT = 2 + 2 * N_RUNS * (2 + N_WRITES) + (2 + N_READS) + 2 * 34 + 4;
    localparam int WATCHDOG_CYCLES = 3 * LINE_DOTS * FRAME_LINES + ACCESS_COUNT * 4;

    logic          clk;
    logic          reset_n;
    logic          cs_n;
    ppu_reg_e      rs;
    logic          rw;
    cpu_data_t     cpu_wdata;
    cpu_data_t     cpu_rdata;
    logic          int_n;
    logic          vram_rd_n;
    logic          vram_we_n;
    vram_addr_t    vram_address;
    cpu_data_t     vram_wdata;
    cpu_data_t     vram_rdata;
    logic [8:0]    video_x;
    logic [8:0]    video_y;
    logic          video_visible;
    colour_index_t colour_index;
    logic [31:0]   rng_state;

    // reference state, advanced on each rising edge
    logic [8:0]    exp_x;
    logic [8:0]    exp_y;
    cpu_data_t     exp_ctrl;
    ppu_addr_t     exp_addr;
    logic          exp_w;
    logic          exp_flag;
    logic          exp_rd_n;
    logic          exp_we_n;
    vram_addr_t    exp_vaddr;
    cpu_data_t     exp_vdata;
    cpu_data_t     exp_buf;
    colour_index_t exp_pal [0:31];
    logic          exp_visible;
    colour_index_t exp_colour;
    logic          exp_int_n;
    cpu_data_t     exp_rdata;

    ppu
    #(
        .P_LINE_DOTS     (LINE_DOTS),
        .P_FRAME_LINES   (FRAME_LINES),
        .P_VISIBLE_DOTS  (VIS_DOTS),
        .P_VISIBLE_LINES (VIS_LINES)
    )
    ppu_inst
    (
        .i_clk (clk), .i_reset_n (reset_n), .i_cs_n (cs_n), .i_rs (rs), .i_rw (rw),
        .i_data (cpu_wdata), .o_data (cpu_rdata), .o_int_n (int_n),
        .o_vram_rd_n (vram_rd_n), .o_vram_we_n (vram_we_n), .o_vram_address (vram_address),
        .o_vram_data (vram_wdata), .i_vram_data (vram_rdata), .o_video_x (video_x),
        .o_video_y (video_y), .o_video_visible (video_visible), .o_colour_index (colour_index)
    );

    ppu_vram_model vram_model_inst
    (
        .i_clk (clk), .i_rd_n (vram_rd_n), .i_we_n (vram_we_n),
        .i_address (vram_address), .i_data (vram_wdata), .o_data (vram_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            exp_x <= '0;
            exp_y <= '0;
            exp_ctrl <= '0;
            exp_addr <= '0;
            exp_w <= 1'b0;
            exp_flag <= 1'b0;
            exp_rd_n <= 1'b1;
            exp_we_n <= 1'b1;
            exp_buf <= '0;
        end
        else
        begin
            exp_x <= (exp_x == LINE_DOTS - 1) ? 9'd0 : exp_x + 9'd1;
            if (exp_x == LINE_DOTS - 1)
            begin
                exp_y <= (exp_y == FRAME_LINES - 1) ? 9'd0 : exp_y + 9'd1;
            end
            exp_rd_n <= 1'b1;
            exp_we_n <= 1'b1;
            if (!exp_rd_n)
            begin
                exp_buf <= vram_rdata;          // byte the model put on the bus
            end
            if (exp_x == 0 && exp_y == FRAME_LINES - 1)
            begin
                exp_flag <= 1'b0;
            end
            else if (exp_x == 0 && exp_y == VIS_LINES + 2)
            begin
                exp_flag <= 1'b1;
            end
            if (!cs_n && rs == RS_PPUCTRL && rw != RW_READ)
            begin
                exp_ctrl <= cpu_wdata;
            end
            if (!cs_n && rs == RS_PPUSTATUS && rw == RW_READ)
            begin
                exp_flag <= 1'b0;               // later assignment beats the vblank set
                exp_w <= 1'b0;
            end
            if (!cs_n && rs == RS_PPUADDR && rw != RW_READ)
            begin
                if (!exp_w)
                begin
                    exp_addr[15:8] <= cpu_wdata;
                end
                else
                begin
                    exp_addr[7:0] <= cpu_wdata;
                end
                exp_w <= !exp_w;
            end
            if (!cs_n && rs == RS_PPUDATA)
            begin
                if (exp_addr < PALETTE_BASE)
                begin
                    exp_vaddr <= exp_addr[13:0];
                    exp_rd_n <= (rw != RW_READ);
                    exp_we_n <= (rw == RW_READ);
                    if (rw != RW_READ)
                    begin
                        exp_vdata <= cpu_wdata;
                        exp_buf <= cpu_wdata;
                    end
                end
                else if (rw != RW_READ)
                begin
                    exp_pal[exp_addr[4:0]] <= cpu_wdata[5:0];
                end
                exp_addr <= exp_addr + (exp_ctrl[CTRL_INC32_BIT] ? 16'd32 : 16'd1);
            end
        end
    end

    assign exp_visible = (exp_x < VIS_DOTS) && (exp_y < VIS_LINES);
    assign exp_colour = exp_visible ? exp_pal[0] : '0;
    assign exp_int_n = !(exp_flag && exp_ctrl[CTRL_NMI_BIT]);

    always_comb
    begin
        exp_rdata = '0;
        if (!cs_n && rw == RW_READ && rs == RS_PPUSTATUS)
        begin
            exp_rdata[STATUS_VBLANK_BIT] = exp_flag;
        end
        else if (!cs_n && rw == RW_READ && rs == RS_PPUDATA)
        begin
            exp_rdata = (exp_addr >= PALETTE_BASE) ? {2'b00, exp_pal[exp_addr[4:0]]} : exp_buf;
        end
    end

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic fail_run(input string reason);
        $display("%0t: %s", $time, reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    a_reset_state: assert property (@(posedge clk) $rose(reset_n) |->
        (int_n && vram_rd_n && vram_we_n && video_x == 0 && video_y == 0))
        else fail_run("outputs were not at their reset values when reset was released");
    a_x: assert property (@(posedge clk) disable iff (!reset_n) video_x === exp_x)
        else report_mismatch("o_video_x", $sampled(exp_x), $sampled(video_x));
    a_y: assert property (@(posedge clk) disable iff (!reset_n) video_y === exp_y)
        else report_mismatch("o_video_y", $sampled(exp_y), $sampled(video_y));
    a_visible: assert property (@(posedge clk) disable iff (!reset_n)
        video_visible === exp_visible)
        else report_mismatch("o_video_visible", $sampled(exp_visible), $sampled(video_visible));
    a_colour: assert property (@(posedge clk) disable iff (!reset_n) colour_index === exp_colour)
        else report_mismatch("o_colour_index", $sampled(exp_colour), $sampled(colour_index));
    a_rd_n: assert property (@(posedge clk) disable iff (!reset_n) vram_rd_n === exp_rd_n)
        else report_mismatch("o_vram_rd_n", $sampled(exp_rd_n), $sampled(vram_rd_n));
    a_we_n: assert property (@(posedge clk) disable iff (!reset_n) vram_we_n === exp_we_n)
        else report_mismatch("o_vram_we_n", $sampled(exp_we_n), $sampled(vram_we_n));
    a_address: assert property (@(posedge clk) disable iff (!reset_n)
        (!exp_rd_n || !exp_we_n) |-> vram_address === exp_vaddr)
        else report_mismatch("o_vram_address", $sampled(exp_vaddr), $sampled(vram_address));
    a_vram_data: assert property (@(posedge clk) disable iff (!reset_n)
        vram_wdata === (exp_we_n ? 8'h00 : exp_vdata))
        else report_mismatch("o_vram_data", $sampled(exp_we_n ? 8'h00 : exp_vdata),
                             $sampled(vram_wdata));
    a_rdata: assert property (@(posedge clk) disable iff (!reset_n) cpu_rdata === exp_rdata)
        else report_mismatch("o_data", $sampled(exp_rdata), $sampled(cpu_rdata));
    a_int_n: assert property (@(posedge clk) disable iff (!reset_n) int_n === exp_int_n)
        else report_mismatch("o_int_n", $sampled(exp_int_n), $sampled(int_n));

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // one bus cycle with chip select, then one idle cycle
    task automatic cpu_access(input ppu_reg_e sel, input logic read, input cpu_data_t value);
        @(negedge clk);
        cs_n = 1'b0;
        rs = sel;
        rw = read ? RW_READ : ~RW_READ;
        cpu_wdata = value;
        @(negedge clk);
        cs_n = 1'b1;
        rw = RW_READ;
        cpu_wdata = '0;
    endtask

    task automatic load_address(input ppu_addr_t addr);
        cpu_access(RS_PPUADDR, 1'b0, addr[15:8]);
        cpu_access(RS_PPUADDR, 1'b0, addr[7:0]);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * 100);
        fail_run("watchdog expired before the test sequence finished");
    end

    initial
    begin
        rng_state = 32'h26016cce;
        reset_n = 1'b0;
        cs_n = 1'b1;
        rs = RS_PPUCTRL;
        rw = RW_READ;
        cpu_wdata = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // VRAM writes with step 1, then step 32
        for (int mode = 0; mode < 2; mode++)
        begin
            cpu_access(RS_PPUCTRL, 1'b0, mode ? 8'h04 : 8'h00);
            for (int run = 0; run < N_RUNS; run++)
            begin
                load_address(16'(lcg_next() % 32'h3F00));
                for (int n = 0; n < N_WRITES; n++)
                begin
                    cpu_access(RS_PPUDATA, 1'b0, 8'(lcg_next() >> 24));
                end
            end
        end

        // buffered VRAM reads
        load_address(16'(lcg_next() % 32'h3F00));
        for (int n = 0; n < N_READS; n++)
        begin
            cpu_access(RS_PPUDATA, 1'b1, '0);
        end

        // palette fill and read back, entry 0 feeds the backdrop
        cpu_access(RS_PPUCTRL, 1'b0, 8'h00);
        load_address(PALETTE_BASE);
        for (int n = 0; n < 32; n++)
        begin
            cpu_access(RS_PPUDATA, 1'b0, 8'(lcg_next() >> 24));
        end
        load_address(PALETTE_BASE);
        for (int n = 0; n < 32; n++)
        begin
            cpu_access(RS_PPUDATA, 1'b1, '0);
        end

        // NMI enabled, clear any pending flag and wait for the next vblank
        cpu_access(RS_PPUCTRL, 1'b0, 8'h80);
        cpu_access(RS_PPUSTATUS, 1'b1, '0);
        while (int_n)
        begin
            @(negedge clk);
        end
        cpu_access(RS_PPUSTATUS, 1'b1, '0);

        // NMI disabled across a whole vblank start
        cpu_access(RS_PPUCTRL, 1'b0, 8'h00);
        while (video_y != '0)
        begin
            @(negedge clk);                     // this frame's vblank already began
        end
        while (video_y != 9'(VIS_LINES + 3))
        begin
            @(negedge clk);
        end
        @(negedge clk);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* tb.f */
verilog/ppu_pkg.sv
verilog/ppu_timing.sv
verilog/ppu_registers.sv
verilog/ppu_vram_port.sv
verilog/ppu_palette.sv
verilog/ppu.sv
bench/ppu_vram_model.sv
bench/ppu_tb.sv
